// File: verilog/cache_macros.svh
// data cache geometry
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// store shape, 32 lines of one word each
`define CACHE_WAYS 4
`define CACHE_SETS 8

// word address, set index in the low bits
`define CACHE_ADDR_BITS 13

// queue depths toward the next level
// both must stay powers of two for pointer wrap
`define MISS_DEPTH 4
`define WB_DEPTH 4

`endif

// File: verilog/cache_pkg.sv
// data cache types
`include "cache_macros.svh"

package cache_pkg;

  // low address bits pick the set
  typedef logic [$clog2(`CACHE_SETS)-1:0] set_idx_t;

  // remaining high bits form the tag
  typedef logic [`CACHE_ADDR_BITS-$clog2(`CACHE_SETS)-1:0] cache_tag_t;

  // full word address, {tag, set}
  typedef logic [`CACHE_ADDR_BITS-1:0] cache_addr_t;

  typedef logic [$clog2(`CACHE_WAYS)-1:0] way_idx_t;

  // one node per internal tree node
  typedef logic [`CACHE_WAYS-2:0] plru_bits_t;

  typedef logic [63:0] word_t;

endpackage

// File: verilog/tag_cam.sv
// way tag compare
`timescale 1ns/1ps
`include "cache_macros.svh"

module tag_cam (
  input  cache_pkg::cache_tag_t                    lookup_tag,
  input  cache_pkg::cache_tag_t [`CACHE_WAYS-1:0]  line_tags,
  input  logic [`CACHE_WAYS-1:0]                   line_valid,
  output logic                                     hit,
  output cache_pkg::way_idx_t                      hit_way
);

  logic [`CACHE_WAYS-1:0] match;

  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      match[w] = line_valid[w] && (line_tags[w] == lookup_tag);
    end
  end

  // priority-free encode, match is one-hot when it hits
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      if (match[w]) begin
        hit_way = cache_pkg::way_idx_t'(w);
      end
    end
  end

  assign hit = |match;

  // store never allocates a tag that is already valid in the set
  always_comb begin
    assert final ($isunknown(match) || $onehot0(match))
      else $error("tag_cam: tag %h valid in more than one way", lookup_tag);
  end

endmodule

// File: verilog/plru_tree.sv
// tree pseudo-LRU
`timescale 1ns/1ps

// node 0 is the root, node 1 covers ways 0/1, node 2 covers ways 2/3
// a node bit of 1 points at the upper half

module plru_tree (
  input  cache_pkg::plru_bits_t node_bits,
  input  cache_pkg::way_idx_t   touch_way,
  output cache_pkg::plru_bits_t touched_bits,
  output cache_pkg::way_idx_t   victim_way
);

  // touch points every node on the path away from the way
  always_comb begin
    touched_bits    = node_bits;
    touched_bits[0] = ~touch_way[1];
    if (touch_way[1]) begin
      touched_bits[2] = ~touch_way[0];
    end else begin
      touched_bits[1] = ~touch_way[0];
    end
  end

  // follow the pointers down from the root
  always_comb begin
    victim_way[1] = node_bits[0];
    if (node_bits[0]) begin
      victim_way[0] = node_bits[2];
    end else begin
      victim_way[0] = node_bits[1];
    end
  end

endmodule

// File: verilog/cachemem.sv
// set-associative line store
`timescale 1ns/1ps
`include "cache_macros.svh"

module cachemem (
  input  logic                           clock,
  input  logic                           reset,
  input  logic [1:0]                     read_en,
  input  cache_pkg::cache_addr_t [1:0]   read_addr,
  output cache_pkg::word_t [1:0]         read_data,
  output logic [1:0]                     read_hit,
  input  logic                           write_en,
  input  cache_pkg::cache_addr_t         write_addr,
  input  cache_pkg::word_t               write_data,
  input  logic                           write_dirty,
  output logic [1:0]                     miss_push,
  output cache_pkg::cache_addr_t [1:0]   miss_addr,
  output logic                           evict_valid,
  output cache_pkg::cache_addr_t         evict_addr,
  output cache_pkg::word_t               evict_data,
  output logic                           evict_dirty
);

  cache_pkg::word_t                        data_q  [`CACHE_SETS][`CACHE_WAYS];
  cache_pkg::cache_tag_t [`CACHE_WAYS-1:0] tags_q  [`CACHE_SETS];
  logic [`CACHE_WAYS-1:0]                  valid_q [`CACHE_SETS];
  logic [`CACHE_WAYS-1:0]                  dirty_q [`CACHE_SETS];
  cache_pkg::plru_bits_t                   plru_q  [`CACHE_SETS];

  cache_pkg::set_idx_t         wr_set;
  cache_pkg::cache_tag_t       wr_tag;
  logic                        wr_hit;
  cache_pkg::way_idx_t         wr_hit_way;
  cache_pkg::way_idx_t         victim_way;
  cache_pkg::way_idx_t         wr_way;
  cache_pkg::plru_bits_t       wr_touched;

  cache_pkg::set_idx_t [1:0]   rd_set;
  cache_pkg::cache_tag_t [1:0] rd_tag;
  logic [1:0]                  rd_store_hit;
  cache_pkg::way_idx_t [1:0]   rd_way;
  logic [1:0]                  rd_fwd;
  logic [1:0]                  rd_touch;
  cache_pkg::plru_bits_t       rd0_base;
  cache_pkg::plru_bits_t       rd0_touched;
  cache_pkg::plru_bits_t       rd1_base;
  cache_pkg::plru_bits_t       rd1_touched;

  assign {wr_tag, wr_set} = write_addr;

  tag_cam wr_cam (
    .lookup_tag (wr_tag),
    .line_tags  (tags_q[wr_set]),
    .line_valid (valid_q[wr_set]),
    .hit        (wr_hit),
    .hit_way    (wr_hit_way)
  );

  // victim comes from the bits before this cycle's touches
  plru_tree victim_tree (
    .node_bits    (plru_q[wr_set]),
    .touch_way    (wr_hit_way),
    .touched_bits (),
    .victim_way   (victim_way)
  );

  assign wr_way = wr_hit ? wr_hit_way : victim_way;

  plru_tree wr_tree (
    .node_bits    (plru_q[wr_set]),
    .touch_way    (wr_way),
    .touched_bits (wr_touched),
    .victim_way   ()
  );

  // write miss pushes out whatever valid line sat in the victim way
  assign evict_valid = write_en & ~wr_hit & valid_q[wr_set][victim_way];
  assign evict_addr  = {tags_q[wr_set][victim_way], wr_set};
  assign evict_data  = data_q[wr_set][victim_way];
  assign evict_dirty = dirty_q[wr_set][victim_way];

  for (genvar p = 0; p < 2; p++) begin : g_read
    assign {rd_tag[p], rd_set[p]} = read_addr[p];

    tag_cam rd_cam (
      .lookup_tag (rd_tag[p]),
      .line_tags  (tags_q[rd_set[p]]),
      .line_valid (valid_q[rd_set[p]]),
      .hit        (rd_store_hit[p]),
      .hit_way    (rd_way[p])
    );

    // same-cycle write wins over storage
    assign rd_fwd[p]    = write_en & (write_addr == read_addr[p]);
    assign read_hit[p]  = read_en[p] & (rd_fwd[p] | rd_store_hit[p]);
    assign read_data[p] = rd_fwd[p] ? write_data : data_q[rd_set[p]][rd_way[p]];
    assign miss_push[p] = read_en[p] & ~read_hit[p];
    assign miss_addr[p] = read_addr[p];
    assign rd_touch[p]  = read_en[p] & rd_store_hit[p] & ~rd_fwd[p];
  end

  // lru chain goes from the write to read 0 to read 1
  assign rd0_base = (write_en && rd_set[0] == wr_set) ? wr_touched : plru_q[rd_set[0]];

  plru_tree rd0_tree (
    .node_bits    (rd0_base),
    .touch_way    (rd_way[0]),
    .touched_bits (rd0_touched),
    .victim_way   ()
  );

  assign rd1_base = (rd_touch[0] && rd_set[1] == rd_set[0]) ? rd0_touched :
                    (write_en && rd_set[1] == wr_set)      ? wr_touched  :
                                                             plru_q[rd_set[1]];

  plru_tree rd1_tree (
    .node_bits    (rd1_base),
    .touch_way    (rd_way[1]),
    .touched_bits (rd1_touched),
    .victim_way   ()
  );

  always_ff @(posedge clock) begin
    if (write_en) begin
      data_q[wr_set][wr_way] <= write_data;
      tags_q[wr_set][wr_way] <= wr_tag;
    end
  end

  // later assignments carry the earlier updates of the same set
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        valid_q[s] <= '0;
        dirty_q[s] <= '0;
        plru_q[s]  <= '0;
      end
    end else begin
      if (write_en) begin
        valid_q[wr_set][wr_way] <= 1'b1;
        dirty_q[wr_set][wr_way] <= write_dirty;
        plru_q[wr_set]          <= wr_touched;
      end
      if (rd_touch[0]) begin
        plru_q[rd_set[0]] <= rd0_touched;
      end
      if (rd_touch[1]) begin
        plru_q[rd_set[1]] <= rd1_touched;
      end
    end
  end

endmodule

// File: verilog/miss_queue.sv
// read miss FIFO
`timescale 1ns/1ps
`include "cache_macros.svh"

module miss_queue (
  input  logic                                clock,
  input  logic                                reset,
  input  logic [1:0]                          miss_push,
  input  cache_pkg::cache_addr_t [1:0]        miss_addr,
  output logic [$clog2(`MISS_DEPTH+1)-1:0]    free_slots,
  output logic                                miss_out_valid,
  output cache_pkg::cache_addr_t              miss_out_addr,
  input  logic                                miss_out_ready
);

  localparam int PTR_BITS   = $clog2(`MISS_DEPTH);
  localparam int COUNT_BITS = $clog2(`MISS_DEPTH + 1);

  cache_pkg::cache_addr_t entries [`MISS_DEPTH];
  logic [PTR_BITS-1:0]    head;
  logic [PTR_BITS-1:0]    tail;
  logic [PTR_BITS-1:0]    second_slot;
  logic [COUNT_BITS-1:0]  count;
  logic                   push_first;
  logic                   push_second;
  logic                   pop;

  // both ports missing on one address make a single entry
  assign push_first  = miss_push[0];
  assign push_second = miss_push[1] & ~(miss_push[0] && miss_addr[0] == miss_addr[1]);
  assign second_slot = tail + PTR_BITS'(push_first);

  assign pop            = miss_out_valid & miss_out_ready;
  assign miss_out_valid = (count != '0);
  assign miss_out_addr  = entries[head];
  assign free_slots     = COUNT_BITS'(`MISS_DEPTH) - count;

  always_ff @(posedge clock) begin
    if (push_first) begin
      entries[tail] <= miss_addr[0];
    end
    if (push_second) begin
      entries[second_slot] <= miss_addr[1];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      tail  <= tail + PTR_BITS'(push_first) + PTR_BITS'(push_second);
      head  <= head + PTR_BITS'(pop);
      count <= count + COUNT_BITS'(push_first) + COUNT_BITS'(push_second)
               - COUNT_BITS'(pop);
    end
  end

  // requester holds off on busy, so pushes always fit
  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    (COUNT_BITS'(push_first) + COUNT_BITS'(push_second)) <= free_slots)
    else $error("miss_queue: push while full");

  a_hold: assert property (@(posedge clock) disable iff (reset)
    miss_out_valid && !miss_out_ready |=> miss_out_valid && $stable(miss_out_addr))
    else $error("miss_queue: head changed without a transfer");

endmodule

// File: verilog/writeback_buffer.sv
// dirty eviction buffer
`timescale 1ns/1ps
`include "cache_macros.svh"

module writeback_buffer (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    evict_valid,
  input  cache_pkg::cache_addr_t  evict_addr,
  input  cache_pkg::word_t        evict_data,
  input  logic                    evict_dirty,
  output logic                    full,
  output logic                    wb_out_valid,
  output cache_pkg::cache_addr_t  wb_out_addr,
  output cache_pkg::word_t        wb_out_data,
  input  logic                    wb_out_ready
);

  localparam int PTR_BITS   = $clog2(`WB_DEPTH);
  localparam int COUNT_BITS = $clog2(`WB_DEPTH + 1);

  cache_pkg::cache_addr_t addr_mem [`WB_DEPTH];
  cache_pkg::word_t       data_mem [`WB_DEPTH];
  logic [PTR_BITS-1:0]    head;
  logic [PTR_BITS-1:0]    tail;
  logic [COUNT_BITS-1:0]  count;
  logic                   push;
  logic                   pop;

  // clean lines match the next level already
  assign push = evict_valid & evict_dirty;
  assign pop  = wb_out_valid & wb_out_ready;

  assign full         = (count == COUNT_BITS'(`WB_DEPTH));
  assign wb_out_valid = (count != '0);
  assign wb_out_addr  = addr_mem[head];
  assign wb_out_data  = data_mem[head];

  always_ff @(posedge clock) begin
    if (push) begin
      addr_mem[tail] <= evict_addr;
      data_mem[tail] <= evict_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      tail  <= tail + PTR_BITS'(push);
      head  <= head + PTR_BITS'(pop);
      count <= count + COUNT_BITS'(push) - COUNT_BITS'(pop);
    end
  end

  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    !(push && full))
    else $error("writeback_buffer: dirty eviction while full");

endmodule

// File: verilog/dcache_top.sv
// data cache top
`timescale 1ns/1ps
`include "cache_macros.svh"

module dcache_top (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [1:0]                    read_en,
  input  cache_pkg::cache_addr_t [1:0]  read_addr,
  output cache_pkg::word_t [1:0]        read_data,
  output logic [1:0]                    read_hit,
  input  logic                          write_en,
  input  cache_pkg::cache_addr_t        write_addr,
  input  cache_pkg::word_t              write_data,
  input  logic                          write_dirty,
  output logic                          busy,
  output logic                          miss_out_valid,
  output cache_pkg::cache_addr_t        miss_out_addr,
  input  logic                          miss_out_ready,
  output logic                          wb_out_valid,
  output cache_pkg::cache_addr_t        wb_out_addr,
  output cache_pkg::word_t              wb_out_data,
  input  logic                          wb_out_ready
);

  logic [1:0]                             miss_push;
  cache_pkg::cache_addr_t [1:0]           miss_addr;
  logic [$clog2(`MISS_DEPTH+1)-1:0]       miss_free;
  logic                                   evict_valid;
  cache_pkg::cache_addr_t                 evict_addr;
  cache_pkg::word_t                       evict_data;
  logic                                   evict_dirty;
  logic                                   wb_full;

  cachemem cachemem_i (
    .clock       (clock),
    .reset       (reset),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .read_data   (read_data),
    .read_hit    (read_hit),
    .write_en    (write_en),
    .write_addr  (write_addr),
    .write_data  (write_data),
    .write_dirty (write_dirty),
    .miss_push   (miss_push),
    .miss_addr   (miss_addr),
    .evict_valid (evict_valid),
    .evict_addr  (evict_addr),
    .evict_data  (evict_data),
    .evict_dirty (evict_dirty)
  );

  miss_queue miss_queue_i (
    .clock          (clock),
    .reset          (reset),
    .miss_push      (miss_push),
    .miss_addr      (miss_addr),
    .free_slots     (miss_free),
    .miss_out_valid (miss_out_valid),
    .miss_out_addr  (miss_out_addr),
    .miss_out_ready (miss_out_ready)
  );

  writeback_buffer writeback_buffer_i (
    .clock        (clock),
    .reset        (reset),
    .evict_valid  (evict_valid),
    .evict_addr   (evict_addr),
    .evict_data   (evict_data),
    .evict_dirty  (evict_dirty),
    .full         (wb_full),
    .wb_out_valid (wb_out_valid),
    .wb_out_addr  (wb_out_addr),
    .wb_out_data  (wb_out_data),
    .wb_out_ready (wb_out_ready)
  );

  // two reads can miss in one cycle, a write evicts at most one line
  assign busy = (miss_free < 2) | wb_full;

endmodule

// File: sim/cache_model.svh
// cache reference model
`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

cache_pkg::word_t       m_data  [`CACHE_SETS][`CACHE_WAYS];
cache_pkg::cache_tag_t  m_tag   [`CACHE_SETS][`CACHE_WAYS];
logic                   m_valid [`CACHE_SETS][`CACHE_WAYS];
logic                   m_dirty [`CACHE_SETS][`CACHE_WAYS];
cache_pkg::plru_bits_t  m_plru  [`CACHE_SETS];

// expected contents of both drain queues, oldest first
cache_pkg::cache_addr_t exp_miss    [$];
cache_pkg::cache_addr_t exp_wb_addr [$];
cache_pkg::word_t       exp_wb_data [$];

function automatic cache_pkg::set_idx_t addr_set(input cache_pkg::cache_addr_t addr);
  return addr[$clog2(`CACHE_SETS)-1:0];
endfunction

function automatic cache_pkg::cache_tag_t addr_tag(input cache_pkg::cache_addr_t addr);
  return addr[`CACHE_ADDR_BITS-1:$clog2(`CACHE_SETS)];
endfunction

function automatic void model_reset();
  for (int s = 0; s < `CACHE_SETS; s++) begin
    m_plru[s] = '0;
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      m_valid[s][w] = 1'b0;
      m_dirty[s][w] = 1'b0;
      m_tag[s][w]   = '0;
      m_data[s][w]  = '0;
    end
  end
  exp_miss.delete();
  exp_wb_addr.delete();
  exp_wb_data.delete();
endfunction

// way holding the address, or -1
function automatic int model_find(input cache_pkg::cache_addr_t addr);
  cache_pkg::set_idx_t s;
  s = addr_set(addr);
  for (int w = 0; w < `CACHE_WAYS; w++) begin
    if (m_valid[s][w] && m_tag[s][w] == addr_tag(addr)) begin
      return w;
    end
  end
  return -1;
endfunction

// every node on the path points at the half not touched
function automatic cache_pkg::plru_bits_t model_touch(input cache_pkg::plru_bits_t bits,
                                                       input int way);
  cache_pkg::plru_bits_t nb;
  nb = bits;
  nb[0] = (way < 2);
  if (way < 2) begin
    nb[1] = (way == 0);
  end else begin
    nb[2] = (way == 2);
  end
  return nb;
endfunction

function automatic int model_victim(input cache_pkg::plru_bits_t bits);
  if (!bits[0]) begin
    return bits[1] ? 1 : 0;
  end
  return bits[2] ? 3 : 2;
endfunction

// combinational read result, same-cycle write first
function automatic void model_read(input cache_pkg::cache_addr_t addr, input logic wen,
                                   input cache_pkg::cache_addr_t waddr,
                                   input cache_pkg::word_t wdata,
                                   output logic hit, output cache_pkg::word_t data);
  int way;
  way  = model_find(addr);
  hit  = 1'b0;
  data = '0;
  if (wen && waddr == addr) begin
    hit  = 1'b1;
    data = wdata;
  end else if (way >= 0) begin
    hit  = 1'b1;
    data = m_data[addr_set(addr)][way];
  end
endfunction

// state change at one clock edge
function automatic void model_step(input logic [1:0] ren, input cache_pkg::cache_addr_t ra0,
                                   input cache_pkg::cache_addr_t ra1, input logic wen,
                                   input cache_pkg::cache_addr_t waddr,
                                   input cache_pkg::word_t wdata, input logic wdirty);
  cache_pkg::cache_addr_t ra [2];
  int                     rway [2];
  logic                   rmiss [2];
  logic                   rtouch [2];
  logic                   fwd;
  cache_pkg::set_idx_t    s;
  int                     way;
  ra[0] = ra0;
  ra[1] = ra1;
  for (int p = 0; p < 2; p++) begin
    rway[p]   = model_find(ra[p]);
    fwd       = wen && (waddr == ra[p]);
    rmiss[p]  = ren[p] && !fwd && (rway[p] < 0);
    rtouch[p] = ren[p] && !fwd && (rway[p] >= 0);
  end
  if (rmiss[0]) begin
    exp_miss.push_back(ra[0]);
  end
  if (rmiss[1] && !(rmiss[0] && ra[0] == ra[1])) begin
    exp_miss.push_back(ra[1]);
  end
  if (wen) begin
    s   = addr_set(waddr);
    way = model_find(waddr);
    if (way < 0) begin
      way = model_victim(m_plru[s]);
      if (m_valid[s][way] && m_dirty[s][way]) begin
        exp_wb_addr.push_back({m_tag[s][way], s});
        exp_wb_data.push_back(m_data[s][way]);
      end
    end
    m_valid[s][way] = 1'b1;
    m_dirty[s][way] = wdirty;
    m_tag[s][way]   = addr_tag(waddr);
    m_data[s][way]  = wdata;
    m_plru[s]       = model_touch(m_plru[s], way);
  end
  for (int p = 0; p < 2; p++) begin
    if (rtouch[p]) begin
      m_plru[addr_set(ra[p])] = model_touch(m_plru[addr_set(ra[p])], rway[p]);
    end
  end
endfunction

`endif

// File: sim/dcache_tb.sv
// data cache testbench
`timescale 1ns/1ps
`include "cache_macros.svh"

module dcache_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int NUM_TXN      = 3000;
  localparam int DRAIN_CYCLES = 200;

  logic                         clock;
  logic                         reset;
  logic [1:0]                   read_en;
  cache_pkg::cache_addr_t [1:0] read_addr;
  cache_pkg::word_t [1:0]       read_data;
  logic [1:0]                   read_hit;
  logic                         write_en;
  cache_pkg::cache_addr_t       write_addr;
  cache_pkg::word_t             write_data;
  logic                         write_dirty;
  logic                         busy;
  logic                         miss_out_valid;
  cache_pkg::cache_addr_t       miss_out_addr;
  logic                         miss_out_ready;
  logic                         wb_out_valid;
  cache_pkg::cache_addr_t       wb_out_addr;
  cache_pkg::word_t             wb_out_data;
  logic                         wb_out_ready;

  // drain heads seen while stalled last cycle
  logic                         miss_stalled;
  logic                         wb_stalled;
  cache_pkg::cache_addr_t       held_miss_addr;
  cache_pkg::cache_addr_t       held_wb_addr;
  cache_pkg::word_t             held_wb_data;

  `include "cache_model.svh"

  dcache_top dcache_top_i (
    .clock          (clock),
    .reset          (reset),
    .read_en        (read_en),
    .read_addr      (read_addr),
    .read_data      (read_data),
    .read_hit       (read_hit),
    .write_en       (write_en),
    .write_addr     (write_addr),
    .write_data     (write_data),
    .write_dirty    (write_dirty),
    .busy           (busy),
    .miss_out_valid (miss_out_valid),
    .miss_out_addr  (miss_out_addr),
    .miss_out_ready (miss_out_ready),
    .wb_out_valid   (wb_out_valid),
    .wb_out_addr    (wb_out_addr),
    .wb_out_data    (wb_out_data),
    .wb_out_ready   (wb_out_ready)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input cache_pkg::word_t expected,
                            input cache_pkg::word_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_addr(input string name, input cache_pkg::cache_addr_t expected,
                            input cache_pkg::cache_addr_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("ERROR %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_hit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("ERROR %s expected %b actual %b", name, expected, actual));
    end
  endtask

  // two sets of six tags keep conflicts and evictions common
  function automatic cache_pkg::cache_addr_t pick_addr();
    cache_pkg::set_idx_t   s;
    cache_pkg::cache_tag_t t;
    s = cache_pkg::set_idx_t'($urandom_range(1, 0));
    t = cache_pkg::cache_tag_t'($urandom_range(5, 0) * 37);
    return {t, s};
  endfunction

  task automatic run_cycle(input bit requests_on, input bit force_ready);
    logic             exp_hit;
    cache_pkg::word_t exp_data;
    @(negedge clock);
    if (miss_stalled && (!miss_out_valid || miss_out_addr !== held_miss_addr)) begin
      report_failure("miss port head changed although it was not taken");
    end
    if (wb_stalled && (!wb_out_valid || wb_out_addr !== held_wb_addr ||
                       wb_out_data !== held_wb_data)) begin
      report_failure("write-back port head changed although it was not taken");
    end
    check_hit("busy", (exp_miss.size() > `MISS_DEPTH - 2) ||
                      (exp_wb_addr.size() == `WB_DEPTH), busy);
    read_en  = '0;
    write_en = 1'b0;
    if (requests_on && !busy) begin
      read_en      = 2'($urandom_range(3, 0));
      write_en     = ($urandom_range(2, 0) == 0);
      read_addr[0] = pick_addr();
      read_addr[1] = ($urandom_range(3, 0) == 0) ? read_addr[0] : pick_addr();
      write_addr   = ($urandom_range(3, 0) == 0) ? read_addr[1] : pick_addr();
      write_data   = {$urandom, $urandom};
      write_dirty  = 1'($urandom_range(1, 0));
    end
    miss_out_ready = force_ready || ($urandom_range(1, 0) == 0);
    wb_out_ready   = force_ready || ($urandom_range(2, 0) == 0);
    #2;
    for (int p = 0; p < 2; p++) begin
      model_read(read_addr[p], write_en, write_addr, write_data, exp_hit, exp_data);
      exp_hit = exp_hit & read_en[p];
      check_hit($sformatf("read_hit[%0d]", p), exp_hit, read_hit[p]);
      if (exp_hit) begin
        check_word($sformatf("read_data[%0d]", p), exp_data, read_data[p]);
      end
    end
    check_hit("miss_out_valid", exp_miss.size() != 0, miss_out_valid);
    check_hit("wb_out_valid", exp_wb_addr.size() != 0, wb_out_valid);
    if (miss_out_valid && miss_out_ready) begin
      check_addr("miss drain addr", exp_miss.pop_front(), miss_out_addr);
    end
    if (wb_out_valid && wb_out_ready) begin
      check_addr("write-back addr", exp_wb_addr.pop_front(), wb_out_addr);
      check_word("write-back data", exp_wb_data.pop_front(), wb_out_data);
    end
    miss_stalled   = miss_out_valid && !miss_out_ready;
    wb_stalled     = wb_out_valid && !wb_out_ready;
    held_miss_addr = miss_out_addr;
    held_wb_addr   = wb_out_addr;
    held_wb_data   = wb_out_data;
    model_step(read_en, read_addr[0], read_addr[1], write_en, write_addr, write_data,
               write_dirty);
  endtask

  initial begin
    void'($urandom(3357));
    clock          = 1'b0;
    reset          = 1'b1;
    read_en        = '0;
    read_addr      = '0;
    write_en       = 1'b0;
    write_addr     = '0;
    write_data     = '0;
    write_dirty    = 1'b0;
    miss_out_ready = 1'b0;
    wb_out_ready   = 1'b0;
    miss_stalled   = 1'b0;
    wb_stalled     = 1'b0;
    held_miss_addr = '0;
    held_wb_addr   = '0;
    held_wb_data   = '0;
    model_reset();
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_hit("miss_out_valid after reset", 1'b0, miss_out_valid);
    check_hit("wb_out_valid after reset", 1'b0, wb_out_valid);
    check_hit("busy after reset", 1'b0, busy);
    for (int i = 0; i < NUM_TXN; i++) begin
      run_cycle(1'b1, 1'b0);
    end
    // empty both queues and give one more cycle for the valids to drop
    while (exp_miss.size() != 0 || exp_wb_addr.size() != 0) begin
      run_cycle(1'b0, 1'b1);
    end
    run_cycle(1'b0, 1'b1);
    $display("TESTS PASSED");
    $finish;
  end

  initial begin
    #((NUM_TXN * 20 + DRAIN_CYCLES) * CLK_PERIOD);
    $display("watchdog expired before all tests finished");
    $display("TESTS FAILED");
    $fatal(1, "timeout");
  end

endmodule

// File: compile.f
+incdir+verilog
+incdir+sim
verilog/cache_pkg.sv
verilog/tag_cam.sv
verilog/plru_tree.sv
verilog/cachemem.sv
verilog/miss_queue.sv
verilog/writeback_buffer.sv
verilog/dcache_top.sv
sim/dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the data cache simulation with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter project directory"
  exit 1
fi

verilator --binary --timing --assert --top-module dcache_tb -f compile.f -o dcache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/dcache_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0
